// ==== Makefile ====
SIM      := verilator
TOP      := tb_stq
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Testbench passed$$" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/stq_pkg.sv ====
package stq_pkg;

  // ==============================
  // Queue and data word sizes
  // ==============================
  localparam int STQ_SIZE  = 8;
  localparam int STQ_IDX_W = 3;
  localparam int CNT_W     = 4;   // Holds 0 to STQ_SIZE
  localparam int PADDR_W   = 32;
  localparam int DW_BYTES  = 8;
  localparam int OFFSET_W  = 3;   // Byte offset inside a data word

  typedef logic [STQ_IDX_W-1:0]  stq_idx_t;
  typedef logic [CNT_W-1:0]      stq_cnt_t;
  typedef logic [STQ_SIZE-1:0]   stq_mask_t;
  typedef logic [PADDR_W-1:0]    paddr_t;
  typedef logic [DW_BYTES*8-1:0] dword_t;
  typedef logic [DW_BYTES-1:0]   byte_en_t;
  typedef logic [1:0]            st_size_t;

  // Access size codes
  localparam st_size_t SIZE_B = 2'd0;
  localparam st_size_t SIZE_H = 2'd1;
  localparam st_size_t SIZE_W = 2'd2;
  localparam st_size_t SIZE_D = 2'd3;

  // ==============================
  // Entry life cycle
  // ==============================
  typedef enum logic [2:0] {
    STQ_FREE     = 3'd0,
    STQ_WAIT_EXE = 3'd1,   // Allocated, address and data unknown
    STQ_READY    = 3'd2,
    STQ_COMMIT   = 3'd3,   // Waiting for the drain stage
    STQ_DRAIN    = 3'd4    // Write in flight to the cache
  } stq_state_t;

  // Byte lanes touched by an access of the given size and offset
  function automatic byte_en_t size_be(st_size_t size, logic [OFFSET_W-1:0] offset);
    byte_en_t base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << offset;
  endfunction

  // Store data copied into every lane of its size
  function automatic dword_t size_rep(st_size_t size, dword_t data);
    dword_t rep;
    case (size)
      SIZE_B:  rep = {8{data[7:0]}};
      SIZE_H:  rep = {4{data[15:0]}};
      SIZE_W:  rep = {2{data[31:0]}};
      default: rep = data;
    endcase
    return rep;
  endfunction

endpackage

// ==== files.f ====
+incdir+tb
common/stq_pkg.sv
src/stq_credit_return.sv
stq/stq_entry.sv
stq/stq_fwd_check.sv
stq/stq_drain.sv
stq/stq_top.sv
tb/tb_stq.sv

// ==== src/stq_credit_return.sv ====
`timescale 1ns/10ps

module stq_credit_return (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  stq_pkg::stq_cnt_t i_free_num,
  input  logic              i_alloc,
  output logic              o_credit_valid,
  output stq_pkg::stq_cnt_t o_credit_num
);
  import stq_pkg::*;

  stq_cnt_t         r_credits;   // Credits held by dispatch
  logic [CNT_W:0]   w_avail;     // Held plus returned this cycle

  assign w_avail = {1'b0, r_credits} + (o_credit_valid ? {1'b0, o_credit_num} : '0);

  // One cycle after the free
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_credit_valid <= 1'b0;
      o_credit_num   <= '0;
    end else begin
      o_credit_valid <= i_free_num != '0;
      o_credit_num   <= i_free_num;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= stq_cnt_t'(STQ_SIZE);   // Dispatch starts with every entry
    end else begin
      r_credits <= stq_cnt_t'(w_avail - (CNT_W+1)'(i_alloc));
    end
  end

  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_avail <= (CNT_W+1)'(STQ_SIZE));

  a_credit_underflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> w_avail != '0);

endmodule

// ==== stq/stq_drain.sv ====
`timescale 1ns/10ps

module stq_drain (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_head_commit,
  input  stq_pkg::paddr_t   i_head_paddr,
  input  stq_pkg::dword_t   i_head_data,
  input  stq_pkg::st_size_t i_head_size,
  input  logic              i_wr_ready,
  output logic              o_drain_start,
  output logic              o_drain_done,
  output logic              o_wr_valid,
  output stq_pkg::paddr_t   o_wr_paddr,
  output stq_pkg::dword_t   o_wr_data,
  output stq_pkg::byte_en_t o_wr_be
);
  import stq_pkg::*;

  logic     r_valid;   // One write in flight
  paddr_t   r_paddr;
  dword_t   r_data;
  byte_en_t r_be;

  // Take the head only with an empty stage
  assign o_drain_start = ~r_valid & i_head_commit;
  assign o_drain_done  = r_valid & i_wr_ready;   // Accepted this cycle

  // ==============================
  // Request valid
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      if (o_drain_start) begin
        r_valid <= 1'b1;
      end else if (o_drain_done) begin
        r_valid <= 1'b0;
      end
    end
  end

  // ==============================
  // Request payload
  // ==============================
  always_ff @(posedge i_clk) begin
    if (o_drain_start) begin
      r_paddr <= {i_head_paddr[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};   // Word aligned
      r_data  <= size_rep(i_head_size, i_head_data);
      r_be    <= size_be(i_head_size, i_head_paddr[OFFSET_W-1:0]);
    end
  end

  assign o_wr_valid = r_valid;
  assign o_wr_paddr = r_paddr;
  assign o_wr_data  = r_data;
  assign o_wr_be    = r_be;

  // A stalled request holds until the cache takes it
  a_wr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr_paddr) &&
                                  $stable(o_wr_data) && $stable(o_wr_be));

endmodule

// ==== stq/stq_entry.sv ====
`timescale 1ns/10ps

module stq_entry (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_alloc,
  input  logic                i_flush,
  input  logic                i_drain_start,
  input  logic                i_drain_done,
  input  logic                i_commit,
  input  logic                i_exe,
  input  stq_pkg::paddr_t     i_exe_paddr,
  input  stq_pkg::dword_t     i_exe_data,
  input  stq_pkg::st_size_t   i_exe_size,
  output stq_pkg::stq_state_t o_state,
  output stq_pkg::paddr_t     o_paddr,
  output stq_pkg::dword_t     o_data,
  output stq_pkg::st_size_t   o_size
);
  import stq_pkg::*;

  stq_state_t r_state;
  paddr_t     r_paddr;
  dword_t     r_data;
  st_size_t   r_size;

  // ==============================
  // Entry state machine
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= STQ_FREE;
    end else begin
      case (r_state)
        STQ_FREE: begin
          if (i_alloc) r_state <= STQ_WAIT_EXE;
        end
        STQ_WAIT_EXE: begin
          if (i_flush) begin
            r_state <= STQ_FREE;
          end else if (i_exe) begin
            r_state <= STQ_READY;
          end
        end
        STQ_READY: begin
          if (i_commit) begin
            r_state <= STQ_COMMIT;   // Commit wins over a same-cycle flush
          end else if (i_flush) begin
            r_state <= STQ_FREE;
          end
        end
        STQ_COMMIT: begin
          if (i_drain_start) r_state <= STQ_DRAIN;
        end
        STQ_DRAIN: begin
          if (i_drain_done) r_state <= STQ_FREE;
        end
        default: r_state <= STQ_FREE;
      endcase
    end
  end

  // Address, data and size from the execution pipe
  always_ff @(posedge i_clk) begin
    if (i_exe) begin
      r_paddr <= i_exe_paddr;
      r_data  <= i_exe_data;
      r_size  <= i_exe_size;
    end
  end

  assign o_state = r_state;
  assign o_paddr = r_paddr;
  assign o_data  = r_data;
  assign o_size  = r_size;

  a_alloc_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> r_state == STQ_FREE);

  a_exe_waiting: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_exe |-> r_state == STQ_WAIT_EXE);

  a_commit_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit |-> r_state == STQ_READY);

  a_drain_order: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_drain_done |-> r_state == STQ_DRAIN);

endmodule

// ==== stq/stq_fwd_check.sv ====
`timescale 1ns/10ps

module stq_fwd_check (
  input  stq_pkg::stq_state_t i_state [stq_pkg::STQ_SIZE],
  input  stq_pkg::paddr_t     i_paddr [stq_pkg::STQ_SIZE],
  input  stq_pkg::dword_t     i_data  [stq_pkg::STQ_SIZE],
  input  stq_pkg::st_size_t   i_size  [stq_pkg::STQ_SIZE],
  input  stq_pkg::stq_idx_t   i_head,
  input  logic                i_fwd_valid,
  input  stq_pkg::paddr_t     i_fwd_paddr,
  input  stq_pkg::st_size_t   i_fwd_size,
  output logic                o_fwd_hit,
  output stq_pkg::dword_t     o_fwd_data,
  output stq_pkg::byte_en_t   o_fwd_be,
  output logic                o_fwd_hazard
);
  import stq_pkg::*;

  byte_en_t  w_ld_be;
  byte_en_t  w_ovl_be [STQ_SIZE];   // Bytes shared with the load
  stq_mask_t w_match;
  stq_mask_t w_wait;
  stq_mask_t w_rot;
  stq_idx_t  w_sel_ofs;
  stq_idx_t  w_sel;

  assign w_ld_be = size_be(i_fwd_size, i_fwd_paddr[OFFSET_W-1:0]);

  // ==============================
  // Per-entry compare
  // ==============================
  for (genvar e = 0; e < STQ_SIZE; e++) begin : g_cmp
    logic w_has_data;
    logic w_same_dw;

    assign w_has_data  = (i_state[e] == STQ_READY) | (i_state[e] == STQ_COMMIT) |
                         (i_state[e] == STQ_DRAIN);
    assign w_same_dw   = i_paddr[e][PADDR_W-1:OFFSET_W] == i_fwd_paddr[PADDR_W-1:OFFSET_W];
    assign w_ovl_be[e] = size_be(i_size[e], i_paddr[e][OFFSET_W-1:0]) & w_ld_be;
    assign w_match[e]  = w_has_data & w_same_dw & (|w_ovl_be[e]);
    assign w_wait[e]   = i_state[e] == STQ_WAIT_EXE;
  end

  // Bit 0 becomes the head, so the highest set bit is the youngest
  always_comb begin
    for (int k = 0; k < STQ_SIZE; k++) begin
      w_rot[k] = w_match[i_head + stq_idx_t'(k)];
    end
  end

  always_comb begin
    w_sel_ofs = '0;
    for (int k = 0; k < STQ_SIZE; k++) begin
      if (w_rot[k]) w_sel_ofs = stq_idx_t'(k);
    end
  end

  assign w_sel = i_head + w_sel_ofs;   // Back to the entry index

  assign o_fwd_hit    = i_fwd_valid & (|w_match);
  assign o_fwd_be     = o_fwd_hit ? w_ovl_be[w_sel] : '0;
  // Data laid out in byte lanes to line up with o_fwd_be
  assign o_fwd_data   = o_fwd_hit ? size_rep(i_size[w_sel], i_data[w_sel]) : '0;
  assign o_fwd_hazard = i_fwd_valid & (|w_wait);   // Some older address still unknown

endmodule

// ==== stq/stq_top.sv ====
`timescale 1ns/10ps

module stq_top (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_alloc_valid,
  input  logic               i_flush,
  input  logic               i_commit_valid,
  input  logic               i_wr_ready,
  input  logic               i_exe_valid,
  input  stq_pkg::stq_idx_t  i_exe_idx,
  input  stq_pkg::paddr_t    i_exe_paddr,
  input  stq_pkg::dword_t    i_exe_data,
  input  stq_pkg::st_size_t  i_exe_size,
  input  logic               i_fwd_valid,
  input  stq_pkg::paddr_t    i_fwd_paddr,
  input  stq_pkg::st_size_t  i_fwd_size,
  output stq_pkg::stq_idx_t  o_alloc_idx,
  output logic               o_fwd_hit,
  output stq_pkg::dword_t    o_fwd_data,
  output stq_pkg::byte_en_t  o_fwd_be,
  output logic               o_fwd_hazard,
  output logic               o_wr_valid,
  output stq_pkg::paddr_t    o_wr_paddr,
  output stq_pkg::dword_t    o_wr_data,
  output stq_pkg::byte_en_t  o_wr_be,
  output logic               o_credit_valid,
  output stq_pkg::stq_cnt_t  o_credit_num
);
  import stq_pkg::*;

  stq_idx_t   r_head;        // Oldest entry, drained next
  stq_idx_t   r_cmt;         // Oldest uncommitted entry
  stq_idx_t   r_tail;        // Next slot to allocate
  stq_idx_t   w_cmt_next;
  stq_state_t w_state [STQ_SIZE];
  paddr_t     w_paddr [STQ_SIZE];
  dword_t     w_data  [STQ_SIZE];
  st_size_t   w_size  [STQ_SIZE];
  logic       w_alloc;
  logic       w_drain_start;
  logic       w_drain_done;
  stq_mask_t  w_kill;
  stq_cnt_t   w_kill_cnt;
  stq_cnt_t   w_free_num;

  assign w_alloc     = i_alloc_valid & ~i_flush;   // Flush cancels a same-cycle allocation
  assign w_cmt_next  = i_commit_valid ? r_cmt + stq_idx_t'(1) : r_cmt;
  assign o_alloc_idx = r_tail;

  // ==============================
  // Pointers
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_cmt  <= '0;
      r_tail <= '0;
    end else begin
      if (w_drain_done) begin
        r_head <= r_head + stq_idx_t'(1);
      end
      r_cmt <= w_cmt_next;
      if (i_flush) begin
        r_tail <= w_cmt_next;   // Roll back past the killed entries
      end else if (w_alloc) begin
        r_tail <= r_tail + stq_idx_t'(1);
      end
    end
  end

  for (genvar e = 0; e < STQ_SIZE; e++) begin : g_entry
    logic w_commit_e;

    assign w_commit_e = i_commit_valid & (r_cmt == stq_idx_t'(e));
    // A committing entry survives the flush
    assign w_kill[e]  = i_flush & ((w_state[e] == STQ_WAIT_EXE) |
                                   ((w_state[e] == STQ_READY) & ~w_commit_e));

    stq_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_alloc       (w_alloc & (r_tail == stq_idx_t'(e))),
      .i_flush       (i_flush),
      .i_drain_start (w_drain_start & (r_head == stq_idx_t'(e))),
      .i_drain_done  (w_drain_done & (r_head == stq_idx_t'(e))),
      .i_commit      (w_commit_e),
      .i_exe         (i_exe_valid & (i_exe_idx == stq_idx_t'(e))),
      .i_exe_paddr   (i_exe_paddr),
      .i_exe_data    (i_exe_data),
      .i_exe_size    (i_exe_size),
      .o_state       (w_state[e]),
      .o_paddr       (w_paddr[e]),
      .o_data        (w_data[e]),
      .o_size        (w_size[e])
    );
  end

  // Freed entries this cycle
  always_comb begin
    w_kill_cnt = '0;
    for (int k = 0; k < STQ_SIZE; k++) begin
      w_kill_cnt = w_kill_cnt + stq_cnt_t'(w_kill[k]);
    end
  end

  assign w_free_num = w_kill_cnt + stq_cnt_t'(w_drain_done) +
                      stq_cnt_t'(i_alloc_valid & i_flush);

  stq_fwd_check u_fwd_check (
    .i_state      (w_state),
    .i_paddr      (w_paddr),
    .i_data       (w_data),
    .i_size       (w_size),
    .i_head       (r_head),
    .i_fwd_valid  (i_fwd_valid),
    .i_fwd_paddr  (i_fwd_paddr),
    .i_fwd_size   (i_fwd_size),
    .o_fwd_hit    (o_fwd_hit),
    .o_fwd_data   (o_fwd_data),
    .o_fwd_be     (o_fwd_be),
    .o_fwd_hazard (o_fwd_hazard)
  );

  stq_drain u_drain (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_head_commit (w_state[r_head] == STQ_COMMIT),
    .i_head_paddr  (w_paddr[r_head]),
    .i_head_data   (w_data[r_head]),
    .i_head_size   (w_size[r_head]),
    .i_wr_ready    (i_wr_ready),
    .o_drain_start (w_drain_start),
    .o_drain_done  (w_drain_done),
    .o_wr_valid    (o_wr_valid),
    .o_wr_paddr    (o_wr_paddr),
    .o_wr_data     (o_wr_data),
    .o_wr_be       (o_wr_be)
  );

  stq_credit_return u_credit_return (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_free_num     (w_free_num),
    .i_alloc        (i_alloc_valid),
    .o_credit_valid (o_credit_valid),
    .o_credit_num   (o_credit_num)
  );

  // Dispatch only allocates with a credit, so the tail slot is free
  a_alloc_not_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc_valid |-> w_state[r_tail] == STQ_FREE);

  a_commit_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> w_state[r_cmt] == STQ_READY);

endmodule

// ==== tb/stq_model.svh ====
`ifndef STQ_MODEL_SVH
`define STQ_MODEL_SVH

// ==============================
// Queue contents
// ==============================
stq_state_t m_state [STQ_SIZE];
paddr_t     m_paddr [STQ_SIZE];
dword_t     m_data  [STQ_SIZE];
st_size_t   m_size  [STQ_SIZE];
stq_idx_t   m_head;
stq_idx_t   m_cmt;
stq_idx_t   m_tail;
logic       m_wr_valid;     // Write request on the cache port
paddr_t     m_wr_paddr;
dword_t     m_wr_data;
byte_en_t   m_wr_be;
logic       m_cred_valid;   // Credit return seen after the next edge
stq_cnt_t   m_cred_num;

// Lanes covered by an access, one byte at a time
function automatic byte_en_t lanes_of(st_size_t size, paddr_t addr);
  byte_en_t be;
  int       lo;
  int       len;
  lo  = int'(addr[OFFSET_W-1:0]);
  len = 1 << size;
  for (int b = 0; b < DW_BYTES; b++) begin
    be[b] = (b >= lo) && (b < lo + len);
  end
  return be;
endfunction

// Every lane takes the store byte that matches its position
function automatic dword_t spread(st_size_t size, dword_t data);
  dword_t out;
  int     len;
  len = 1 << size;
  for (int b = 0; b < DW_BYTES; b++) begin
    out[b*8 +: 8] = data[(b % len)*8 +: 8];
  end
  return out;
endfunction

function automatic int live_count();
  int n;
  n = 0;
  for (int e = 0; e < STQ_SIZE; e++) begin
    if (m_state[e] != STQ_FREE) n++;
  end
  return n;
endfunction

task automatic model_reset();
  for (int e = 0; e < STQ_SIZE; e++) begin
    m_state[e] = STQ_FREE;
  end
  m_head       = '0;
  m_cmt        = '0;
  m_tail       = '0;
  m_wr_valid   = 1'b0;
  m_cred_valid = 1'b0;
  m_cred_num   = '0;
endtask

// Walk oldest to youngest, so the last match left standing is the youngest
task automatic fwd_expect(input paddr_t addr, input st_size_t size, output logic hit,
                          output byte_en_t be, output dword_t data, output logic hazard);
  byte_en_t ld;
  byte_en_t ovl;
  stq_idx_t e;
  hit    = 1'b0;
  be     = '0;
  data   = '0;
  hazard = 1'b0;
  ld     = lanes_of(size, addr);
  for (int k = 0; k < STQ_SIZE; k++) begin
    e   = m_head + stq_idx_t'(k);
    ovl = lanes_of(m_size[e], m_paddr[e]) & ld;
    if (m_state[e] == STQ_WAIT_EXE) hazard = 1'b1;
    if ((m_state[e] inside {STQ_READY, STQ_COMMIT, STQ_DRAIN}) &&
        (m_paddr[e][PADDR_W-1:OFFSET_W] == addr[PADDR_W-1:OFFSET_W]) && (ovl != '0)) begin
      hit  = 1'b1;
      be   = ovl;
      data = spread(m_size[e], m_data[e]);
    end
  end
endtask

// One clock edge with the inputs of the current cycle
task automatic model_step(input logic alloc, input logic flush, input logic commit,
                          input logic exe, input stq_idx_t exe_idx, input paddr_t exe_paddr,
                          input dword_t exe_data, input st_size_t exe_size,
                          input logic wr_ready);
  stq_cnt_t freed;
  stq_idx_t cmt_next;
  freed    = '0;
  cmt_next = m_cmt;
  if (m_wr_valid && wr_ready) begin
    m_state[m_head] = STQ_FREE;   // Write accepted
    m_head          = m_head + stq_idx_t'(1);
    m_wr_valid      = 1'b0;
    freed           = freed + stq_cnt_t'(1);
  end else if (!m_wr_valid && m_state[m_head] == STQ_COMMIT) begin
    m_state[m_head] = STQ_DRAIN;
    m_wr_valid      = 1'b1;
    m_wr_paddr      = m_paddr[m_head] & ~paddr_t'(DW_BYTES - 1);
    m_wr_data       = spread(m_size[m_head], m_data[m_head]);
    m_wr_be         = lanes_of(m_size[m_head], m_paddr[m_head]);
  end
  if (exe) begin
    m_state[exe_idx] = STQ_READY;
    m_paddr[exe_idx] = exe_paddr;
    m_data[exe_idx]  = exe_data;
    m_size[exe_idx]  = exe_size;
  end
  if (commit) begin
    m_state[m_cmt] = STQ_COMMIT;
    cmt_next       = m_cmt + stq_idx_t'(1);
  end
  if (flush) begin
    for (int e = 0; e < STQ_SIZE; e++) begin
      if (m_state[e] inside {STQ_WAIT_EXE, STQ_READY}) begin
        m_state[e] = STQ_FREE;
        freed      = freed + stq_cnt_t'(1);
      end
    end
    m_tail = cmt_next;
    if (alloc) freed = freed + stq_cnt_t'(1);   // Cancelled allocation
  end else if (alloc) begin
    m_state[m_tail] = STQ_WAIT_EXE;
    m_tail          = m_tail + stq_idx_t'(1);
  end
  m_cmt        = cmt_next;
  m_cred_valid = freed != '0;
  m_cred_num   = freed;
endtask

`endif

// ==== tb/tb_stq.sv ====
`timescale 1ns/10ps

module tb_stq;
  import stq_pkg::*;

  localparam int NUM_OPS     = 2000;
  localparam int WATCHDOG_NS = NUM_OPS * 20 * 10;

  logic      i_clk;
  logic      i_reset_n;
  logic      i_alloc_valid;
  logic      i_flush;
  logic      i_commit_valid;
  logic      i_wr_ready;
  logic      i_exe_valid;
  stq_idx_t  i_exe_idx;
  paddr_t    i_exe_paddr;
  dword_t    i_exe_data;
  st_size_t  i_exe_size;
  logic      i_fwd_valid;
  paddr_t    i_fwd_paddr;
  st_size_t  i_fwd_size;
  stq_idx_t  o_alloc_idx;
  logic      o_fwd_hit;
  dword_t    o_fwd_data;
  byte_en_t  o_fwd_be;
  logic      o_fwd_hazard;
  logic      o_wr_valid;
  paddr_t    o_wr_paddr;
  dword_t    o_wr_data;
  byte_en_t  o_wr_be;
  logic      o_credit_valid;
  stq_cnt_t  o_credit_num;

  integer    seed;
  int        err_cnt;
  stq_cnt_t  tb_credits;   // Credits held by dispatch
  logic      prev_stall;   // Write was stalled in the last cycle
  paddr_t    prev_paddr;
  dword_t    prev_data;
  byte_en_t  prev_be;

  `include "stq_model.svh"

  stq_top u_stq_top (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc_valid  (i_alloc_valid),
    .i_flush        (i_flush),
    .i_commit_valid (i_commit_valid),
    .i_wr_ready     (i_wr_ready),
    .i_exe_valid    (i_exe_valid),
    .i_exe_idx      (i_exe_idx),
    .i_exe_paddr    (i_exe_paddr),
    .i_exe_data     (i_exe_data),
    .i_exe_size     (i_exe_size),
    .i_fwd_valid    (i_fwd_valid),
    .i_fwd_paddr    (i_fwd_paddr),
    .i_fwd_size     (i_fwd_size),
    .o_alloc_idx    (o_alloc_idx),
    .o_fwd_hit      (o_fwd_hit),
    .o_fwd_data     (o_fwd_data),
    .o_fwd_be       (o_fwd_be),
    .o_fwd_hazard   (o_fwd_hazard),
    .o_wr_valid     (o_wr_valid),
    .o_wr_paddr     (o_wr_paddr),
    .o_wr_data      (o_wr_data),
    .o_wr_be        (o_wr_be),
    .o_credit_valid (o_credit_valid),
    .o_credit_num   (o_credit_num)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic report_fail();
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
      report_fail();
    end
  endtask

  task automatic check_idx(input string name, input stq_idx_t got, input stq_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
      report_fail();
    end
  endtask

  task automatic check_cnt(input string name, input stq_cnt_t got, input stq_cnt_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      err_cnt++;
      report_fail();
    end
  endtask

  task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      err_cnt++;
      report_fail();
    end
  endtask

  task automatic check_dword(input string name, input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      err_cnt++;
      report_fail();
    end
  endtask

  task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      err_cnt++;
      report_fail();
    end
  endtask

  function automatic int unsigned pick(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Small window of 8 data words, naturally aligned
  function automatic paddr_t rand_addr(st_size_t size);
    paddr_t a;
    a = 32'h0000_1000 | paddr_t'(pick(64));
    return a & ~((paddr_t'(1) << size) - paddr_t'(1));
  endfunction

  // ==============================
  // One clock cycle of stimulus and checks
  // ==============================
  task automatic run_cycle(input bit allow_new);
    stq_cnt_t avail;
    stq_idx_t waiting [$];
    logic     s_alloc;
    logic     s_flush;
    logic     s_commit;
    logic     s_exe;
    stq_idx_t s_exe_idx;
    paddr_t   s_exe_paddr;
    dword_t   s_exe_data;
    st_size_t s_exe_size;
    logic     s_fwd_valid;
    paddr_t   s_fwd_paddr;
    st_size_t s_fwd_size;
    logic     s_wr_ready;
    logic     exp_hit;
    byte_en_t exp_be;
    dword_t   exp_data;
    logic     exp_hazard;

    @(posedge i_clk);
    avail      = tb_credits + (m_cred_valid ? m_cred_num : stq_cnt_t'(0));   // Return due now
    s_flush    = allow_new && (pick(64) == 0);
    s_alloc    = allow_new && (avail != '0) && (pick(3) != 0);
    for (int e = 0; e < STQ_SIZE; e++) begin
      if (m_state[e] == STQ_WAIT_EXE) waiting.push_back(stq_idx_t'(e));
    end
    s_exe       = (waiting.size() != 0) && (pick(2) == 0);
    s_exe_idx   = s_exe ? waiting[pick(waiting.size())] : '0;
    s_exe_size  = st_size_t'(pick(4));
    s_exe_paddr = rand_addr(s_exe_size);
    s_exe_data  = {$random(seed), $random(seed)};
    s_commit    = (m_state[m_cmt] == STQ_READY) && (pick(2) == 0);
    s_fwd_valid = pick(2) == 0;
    s_fwd_size  = st_size_t'(pick(4));
    s_fwd_paddr = rand_addr(s_fwd_size);
    s_wr_ready  = pick(4) != 0;   // Cache stalls now and then

    i_alloc_valid  <= s_alloc;
    i_flush        <= s_flush;
    i_commit_valid <= s_commit;
    i_exe_valid    <= s_exe;
    i_exe_idx      <= s_exe_idx;
    i_exe_paddr    <= s_exe_paddr;
    i_exe_data     <= s_exe_data;
    i_exe_size     <= s_exe_size;
    i_fwd_valid    <= s_fwd_valid;
    i_fwd_paddr    <= s_fwd_paddr;
    i_fwd_size     <= s_fwd_size;
    i_wr_ready     <= s_wr_ready;

    @(negedge i_clk);
    check_idx("o_alloc_idx", o_alloc_idx, m_tail);
    check_bit("o_credit_valid", o_credit_valid, m_cred_valid);
    if (m_cred_valid) check_cnt("o_credit_num", o_credit_num, m_cred_num);
    if (o_credit_valid) tb_credits = tb_credits + o_credit_num;   // Dispatch takes the return
    check_cnt("credits held by dispatch", tb_credits, stq_cnt_t'(STQ_SIZE - live_count()));
    tb_credits = tb_credits - stq_cnt_t'(s_alloc);
    check_bit("o_wr_valid", o_wr_valid, m_wr_valid);
    if (m_wr_valid) begin
      check_paddr("o_wr_paddr", o_wr_paddr, m_wr_paddr);
      check_dword("o_wr_data", o_wr_data, m_wr_data);
      check_byte_en("o_wr_be", o_wr_be, m_wr_be);
    end
    if (prev_stall) begin
      check_paddr("o_wr_paddr under stall", o_wr_paddr, prev_paddr);
      check_dword("o_wr_data under stall", o_wr_data, prev_data);
      check_byte_en("o_wr_be under stall", o_wr_be, prev_be);
    end
    prev_stall = o_wr_valid && !s_wr_ready;
    prev_paddr = o_wr_paddr;
    prev_data  = o_wr_data;
    prev_be    = o_wr_be;

    fwd_expect(s_fwd_paddr, s_fwd_size, exp_hit, exp_be, exp_data, exp_hazard);
    if (s_fwd_valid) begin
      check_bit("o_fwd_hit", o_fwd_hit, exp_hit);
      check_bit("o_fwd_hazard", o_fwd_hazard, exp_hazard);
      if (exp_hit) begin
        check_byte_en("o_fwd_be", o_fwd_be, exp_be);
        check_dword("o_fwd_data", o_fwd_data, exp_data);
      end
    end

    model_step(s_alloc, s_flush, s_commit, s_exe, s_exe_idx, s_exe_paddr, s_exe_data,
               s_exe_size, s_wr_ready);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    seed           = 32'h3ad;
    err_cnt        = 0;
    tb_credits     = stq_cnt_t'(STQ_SIZE);
    prev_stall     = 1'b0;
    i_reset_n      = 1'b0;
    i_alloc_valid  = 1'b0;
    i_flush        = 1'b0;
    i_commit_valid = 1'b0;
    i_wr_ready     = 1'b0;
    i_exe_valid    = 1'b0;
    i_exe_idx      = '0;
    i_exe_paddr    = '0;
    i_exe_data     = '0;
    i_exe_size     = SIZE_B;
    i_fwd_valid    = 1'b0;
    i_fwd_paddr    = '0;
    i_fwd_size     = SIZE_B;
    model_reset();

    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;

    for (int n = 0; n < NUM_OPS; n++) begin
      run_cycle(1'b1);
    end
    // No new stores, let the queue empty out
    while (live_count() != 0 || m_cred_valid) begin
      run_cycle(1'b0);
    end
    check_cnt("credits after drain", tb_credits, stq_cnt_t'(STQ_SIZE));

    if (err_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_fail();
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    report_fail();
  end

endmodule
